// ==== compile.f ====
+incdir+include
design/nodeBusPkg.sv
design/tickTimer.sv
design/localSram.sv
design/busArbiter.sv
design/responseRouter.sv
design/nodeMemFabric.sv
testbench/clockGen.sv
testbench/nodeMemFabric_properties.sv
testbench/nodeMemFabricTb.sv

// ==== Bender.yml ====
package:
  name: nodeMemFabric

sources:
  - include_dirs:
      - include
    files:
      - design/nodeBusPkg.sv
      - design/tickTimer.sv
      - design/localSram.sv
      - design/busArbiter.sv
      - design/responseRouter.sv
      - design/nodeMemFabric.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/clockGen.sv
      - testbench/nodeMemFabric_properties.sv
      - testbench/nodeMemFabricTb.sv

// ==== testbench/nodeMemFabricTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nodeBus_consts.svh"

module nodeMemFabricTb;

	import nodeBusPkg::*;

	localparam int INIT_WORDS = 8;
	localparam int ROT_TXN    = 6;
	localparam int RAND_TXN   = 60;
	localparam int TOTAL_TXN  = `NUM_REQ * (INIT_WORDS + ROT_TXN + RAND_TXN);

	logic                                 EXTCLK;
	logic                                 rstN;
	logic [`NUM_REQ-1:0]                  reqAct;
	busCmdE [`NUM_REQ-1:0]                reqCmd;
	logic [`NUM_REQ-1:0][`ADDR_W-1:0]     reqAddr;
	logic [`NUM_REQ-1:0][`DATA_W-1:0]     reqData;
	logic [`NUM_REQ-1:0][`BE_W-1:0]       reqBe;
	logic [`NUM_REQ-1:0][`REQ_TAG_W-1:0]  reqTag;
	logic [`NUM_REQ-1:0]                  reqNext;
	logic [`NUM_REQ-1:0]                  rspDrdy;
	logic [`DATA_W-1:0]                   rspData;
	logic [`REQ_TAG_W-1:0]                rspTag;
	logic                                 ioNext;
	logic                                 ioDrdy;
	logic [`DATA_W-1:0]                   ioData;
	logic [`BUS_TAG_W-1:0]                ioTag;
	logic                                 ioAct;
	busCmdE                               cmd;
	logic [`ADDR_W-1:0]                   addr;
	logic [`DATA_W-1:0]                   data;
	logic [`BE_W-1:0]                     be;
	logic [`BUS_TAG_W-1:0]                busTag;
	logic                                 tick;

	int          cycleCnt = 0;
	int          errCount = 0;
	int          pendingCnt [`NUM_REQ];
	int          actSince [`NUM_REQ];
	int          lastGrant [`NUM_REQ];
	bit          ioRdPending [`NUM_REQ];
	int          tagCtr [`NUM_REQ];
	logic [63:0] expData [`NUM_REQ][512];
	bit          expValid [`NUM_REQ][512];
	bit          expSram [`NUM_REQ][512];
	int          expGrant [`NUM_REQ][512];
	logic [63:0] shadow [logic [41:0]];
	logic [63:0] ioMem [logic [41:0]];
	logic [63:0] rspDataQ [$];
	logic [10:0] rspTagQ [$];
	int          rspDueQ [$];

	clockGen i_clockGen (
		.EXTCLK (EXTCLK),
		.rstN   (rstN)
	);

	nodeMemFabric i_nodeMemFabric (
		.EXTCLK (EXTCLK), .rstN (rstN),
		.reqAct (reqAct), .reqCmd (reqCmd), .reqAddr (reqAddr),
		.reqData (reqData), .reqBe (reqBe), .reqTag (reqTag),
		.reqNext (reqNext), .rspDrdy (rspDrdy), .rspData (rspData), .rspTag (rspTag),
		.ioNext (ioNext), .ioDrdy (ioDrdy), .ioData (ioData), .ioTag (ioTag),
		.ioAct (ioAct), .cmd (cmd), .addr (addr), .data (data), .be (be),
		.busTag (busTag), .tick (tick)
	);

	always @(posedge EXTCLK)
		cycleCnt <= cycleCnt + 1;

	// ==============================
	// helpers
	// ==============================

	// unwritten io words get a pattern over the whole word address
	function automatic logic [63:0] fillPattern(input logic [41:0] key);
		return {key[21:0], key} ^ 64'hc3a5_96f0_0f69_5a3c;
	endfunction

	function automatic logic [63:0] mergeBytes(input logic [63:0] old, input logic [63:0] nw,
		input logic [7:0] bev);
		logic [63:0] res;
		res = old;
		for (int b = 0; b < 8; b++)
			if (bev[b])
				res[b*8 +: 8] = nw[b*8 +: 8];
		return res;
	endfunction

	// a waiting request other than an io read is passed over at most once
	task automatic checkRotation(input int id);
		for (int j = 0; j < `NUM_REQ; j++)
			if (j != id && reqAct[j] && !ioRdPending[j] && lastGrant[id] >= 0)
				assert (actSince[j] >= lastGrant[id])
				else
				begin
					$display("Requester %0d granted twice while requester %0d waited", id, j);
					errCount++;
				end
	endtask

	task automatic issueRequest(input int id, input bit isIo, input bit isWrite,
		input int word, input logic [7:0] bev, input logic [63:0] wdata);
		logic [`ADDR_W-1:0] a;
		logic [41:0]        key;
		logic [63:0]        cur;
		int                 t;
		a   = (`ADDR_W'(id * 64 + word) << 3) | (isIo ? (`ADDR_W'(1) << 44) : '0);
		key = a[44:3];
		t   = tagCtr[id];
		reqCmd[id]      = isWrite ? CMD_WRITE : CMD_READ;
		reqAddr[id]     = a;
		reqData[id]     = wdata;
		reqBe[id]       = bev;
		reqTag[id]      = t[8:0];
		actSince[id]    = cycleCnt;
		ioRdPending[id] = isIo && !isWrite;
		reqAct[id]      = 1'b1;
		do
			@(negedge EXTCLK);
		while (!reqNext[id]);
		checkRotation(id);
		lastGrant[id]   = cycleCnt;
		reqAct[id]      = 1'b0;
		ioRdPending[id] = 1'b0;
		cur = shadow.exists(key) ? shadow[key] : fillPattern(key);
		if (isWrite)
			shadow[key] = mergeBytes(cur, wdata, bev);
		else
		begin
			expData[id][t]  = cur;
			expValid[id][t] = 1'b1;
			expSram[id][t]  = !isIo;
			expGrant[id][t] = cycleCnt;
			pendingCnt[id]++;
		end
		tagCtr[id] = (t + 1) % 512;
		// request fields held through the rising edge that samples reqNext
		@(negedge EXTCLK);
	endtask

	task automatic runRequester(input int id);
		logic [7:0] bev;
		// full words first so every sram word has known content
		for (int w = 0; w < INIT_WORDS; w++)
			issueRequest(id, 1'b0, 1'b1, w, 8'hff, {$urandom, $urandom});
		// back to back sram reads from all lanes
		for (int n = 0; n < ROT_TXN; n++)
			issueRequest(id, 1'b0, 1'b0, n % INIT_WORDS, 8'h00, '0);
		for (int n = 0; n < RAND_TXN; n++)
		begin
			bev = 8'($urandom);
			if (bev == 8'h00)
				bev = 8'hff;
			issueRequest(id, $urandom_range(0, 1), $urandom_range(0, 4) < 2,
				$urandom_range(0, INIT_WORDS - 1), bev, {$urandom, $urandom});
			repeat ($urandom_range(0, 2)) @(negedge EXTCLK);
		end
	endtask

	// ==============================
	// io target model
	// ==============================

	initial
	begin
		int          waitLeft;
		logic [41:0] key;
		logic [63:0] cur;
		waitLeft = -1;
		forever
		begin
			@(negedge EXTCLK);
			if (ioNext)
			begin
				// taken at the edge just passed with the fields still held
				key = addr[44:3];
				cur = ioMem.exists(key) ? ioMem[key] : fillPattern(key);
				if (cmd == CMD_WRITE)
					ioMem[key] = mergeBytes(cur, data, be);
				else
				begin
					rspDataQ.push_back(cur);
					rspTagQ.push_back(busTag);
					rspDueQ.push_back(cycleCnt + $urandom_range(2, 12));
				end
				ioNext   = 1'b0;
				waitLeft = -1;
			end
			else if (ioAct && rstN)
			begin
				if (waitLeft < 0)
					waitLeft = $urandom_range(0, 3);
				if (waitLeft == 0)
					ioNext = 1'b1;
				else
					waitLeft--;
			end
			// one due response per cycle in any order
			ioDrdy = 1'b0;
			for (int k = 0; k < rspDueQ.size(); k++)
				if (!ioDrdy && rspDueQ[k] <= cycleCnt)
				begin
					ioDrdy = 1'b1;
					ioData = rspDataQ[k];
					ioTag  = rspTagQ[k];
					rspDataQ.delete(k);
					rspTagQ.delete(k);
					rspDueQ.delete(k);
				end
		end
	end

	// ==============================
	// response scoreboard
	// ==============================

	always @(negedge EXTCLK)
	begin
		int t;
		t = int'(rspTag);
		if (rstN)
			for (int id = 0; id < `NUM_REQ; id++)
				if (rspDrdy[id])
				begin
					assert (expValid[id][t])
					else
					begin
						$display("Unexpected response on lane %0d with tag %0h", id, t);
						errCount++;
					end
					if (expValid[id][t])
					begin
						assert (rspData == expData[id][t])
						else
						begin
							$display("FAIL %s expected %h actual %h",
								expSram[id][t] ? "sram_data" : "io_data",
								expData[id][t], rspData);
							errCount++;
						end
						if (expSram[id][t])
							assert (cycleCnt - expGrant[id][t] == 3)
							else
							begin
								$display("FAIL sram_latency expected %0d actual %0d",
									3, cycleCnt - expGrant[id][t]);
								errCount++;
							end
						expValid[id][t] = 1'b0;
						pendingCnt[id]--;
					end
				end
	end

	// ==============================
	// main sequence
	// ==============================

	initial
	begin
		void'($urandom(32'h33d7));
		reqAct  = '0;
		reqCmd  = {`NUM_REQ{CMD_READ}};
		reqAddr = '0;
		reqData = '0;
		reqBe   = '0;
		reqTag  = '0;
		ioNext  = 1'b0;
		ioDrdy  = 1'b0;
		ioData  = '0;
		ioTag   = '0;
		for (int i = 0; i < `NUM_REQ; i++)
		begin
			pendingCnt[i]  = 0;
			actSince[i]    = 0;
			lastGrant[i]   = -1;
			ioRdPending[i] = 1'b0;
			tagCtr[i]      = 0;
		end
		@(posedge rstN);
		@(negedge EXTCLK);
		fork
			runRequester(0);
			runRequester(1);
			runRequester(2);
		join
		while (pendingCnt[0] + pendingCnt[1] + pendingCnt[2] != 0)
			@(negedge EXTCLK);
		// a few more tick periods
		repeat (3 * `TCK_SCALE) @(negedge EXTCLK);
		$display("Checks done: testbench errors %0d, assertion failures %0d",
			errCount, i_nodeMemFabric.propChk.failCount);
		if (errCount + i_nodeMemFabric.propChk.failCount == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// watchdog allows 40 clocks per transaction
	initial
	begin
		#(TOTAL_TXN * 40 * 20);
		$display("Watchdog expired before all transactions completed");
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/nodeMemFabric_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nodeBus_consts.svh"

module nodeMemFabric_properties
(
	input wire                       EXTCLK,
	input wire                       rstN,
	input wire  [`NUM_REQ-1:0]       reqNext,
	input wire  [`NUM_REQ-1:0]       rspDrdy,
	input wire                       ioAct,
	input wire                       ioNext,
	input wire                       ioDrdy,
	input nodeBusPkg::busCmdE        cmd,
	input wire  [`ADDR_W-1:0]        addr,
	input wire                       tick
);

	import nodeBusPkg::*;

	int         failCount = 0;
	logic [3:0] ioPend;

	// io reads taken by the target and not answered yet
	always_ff @(posedge EXTCLK)
	begin
		if (!rstN)
			ioPend <= '0;
		else
			ioPend <= ioPend + 4'(ioAct && ioNext && (cmd == CMD_READ)) - 4'(ioDrdy);
	end

	// ==============================
	// reset and handshakes
	// ==============================

	assert property (@(posedge EXTCLK)
		!rstN |=> (reqNext == '0 && rspDrdy == '0 && !ioAct && !tick))
		else
		begin
			failCount++;
			$error("outputs active during or right after reset");
		end

	// io request held until the target takes it
	assert property (@(posedge EXTCLK) disable iff (!rstN)
		ioAct && !ioNext |=> ioAct && $stable(addr) && $stable(cmd))
		else
		begin
			failCount++;
			$error("ioAct dropped or changed before ioNext");
		end

	assert property (@(posedge EXTCLK) disable iff (!rstN)
		ioAct && (cmd == CMD_READ) |-> ioPend < `IO_MAX_OUT)
		else
		begin
			failCount++;
			$error("io read issued with the outstanding limit reached");
		end

	// ==============================
	// time base
	// ==============================

	assert property (@(posedge EXTCLK) disable iff (!rstN)
		tick |=> !tick [*`TCK_SCALE-1] ##1 tick)
		else
		begin
			failCount++;
			$error("tick period or width wrong");
		end

	assert property (@(posedge EXTCLK)
		$rose(rstN) |-> !tick [*`TCK_SCALE] ##1 tick)
		else
		begin
			failCount++;
			$error("first tick not one period after reset");
		end

endmodule

bind nodeMemFabric nodeMemFabric_properties propChk (
	.EXTCLK  (EXTCLK),
	.rstN    (rstN),
	.reqNext (reqNext),
	.rspDrdy (rspDrdy),
	.ioAct   (ioAct),
	.ioNext  (ioNext),
	.ioDrdy  (ioDrdy),
	.cmd     (cmd),
	.addr    (addr),
	.tick    (tick)
);

`default_nettype wire

// ==== testbench/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen
(
	output logic EXTCLK,
	output logic rstN
);

	// 20 ns period
	initial
	begin
		EXTCLK = 1'b0;
		forever #10 EXTCLK = ~EXTCLK;
	end

	// reset held for five clocks, released on a falling edge
	initial
	begin
		rstN = 1'b0;
		repeat (5) @(posedge EXTCLK);
		@(negedge EXTCLK);
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

// ==== design/nodeMemFabric.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nodeBus_consts.svh"

module nodeMemFabric
(
	input  wire                                    EXTCLK,
	input  wire                                    rstN,
	// requester side
	input  wire  [`NUM_REQ-1:0]                    reqAct,
	input  nodeBusPkg::busCmdE [`NUM_REQ-1:0]      reqCmd,
	input  wire  [`NUM_REQ-1:0][`ADDR_W-1:0]       reqAddr,
	input  wire  [`NUM_REQ-1:0][`DATA_W-1:0]       reqData,
	input  wire  [`NUM_REQ-1:0][`BE_W-1:0]         reqBe,
	input  wire  [`NUM_REQ-1:0][`REQ_TAG_W-1:0]    reqTag,
	output logic [`NUM_REQ-1:0]                    reqNext,
	output logic [`NUM_REQ-1:0]                    rspDrdy,
	output logic [`DATA_W-1:0]                     rspData,
	output logic [`REQ_TAG_W-1:0]                  rspTag,
	// external io channel
	input  wire                                    ioNext,
	input  wire                                    ioDrdy,
	input  wire  [`DATA_W-1:0]                     ioData,
	input  wire  [`BUS_TAG_W-1:0]                  ioTag,
	output logic                                   ioAct,
	output nodeBusPkg::busCmdE                     cmd,
	output logic [`ADDR_W-1:0]                     addr,
	output logic [`DATA_W-1:0]                     data,
	output logic [`BE_W-1:0]                       be,
	output logic [`BUS_TAG_W-1:0]                  busTag,
	// time base
	output logic                                   tick
);

	logic                   sramAct;
	logic                   sramDrdy;
	logic [`DATA_W-1:0]     sramData;
	logic [`BUS_TAG_W-1:0]  sramTag;
	logic                   ioRspSeen;

	// ==============================
	// request side
	// ==============================

	busArbiter i_busArbiter (
		.EXTCLK    (EXTCLK),
		.rstN      (rstN),
		.reqAct    (reqAct),
		.reqCmd    (reqCmd),
		.reqAddr   (reqAddr),
		.reqData   (reqData),
		.reqBe     (reqBe),
		.reqTag    (reqTag),
		.ioNext    (ioNext),
		.ioRspSeen (ioRspSeen),
		.reqNext   (reqNext),
		.cmd       (cmd),
		.addr      (addr),
		.data      (data),
		.be        (be),
		.busTag    (busTag),
		.sramAct   (sramAct),
		.ioAct     (ioAct)
	);

	// word index from address bits [14:3]
	localSram i_localSram (
		.EXTCLK   (EXTCLK),
		.sramAct  (sramAct),
		.cmd      (cmd),
		.addr     (addr[`SRAM_WORD_BITS+2:3]),
		.be       (be),
		.data     (data),
		.busTag   (busTag),
		.sramDrdy (sramDrdy),
		.sramData (sramData),
		.sramTag  (sramTag)
	);

	// ==============================
	// response side and time base
	// ==============================

	responseRouter i_responseRouter (
		.EXTCLK    (EXTCLK),
		.rstN      (rstN),
		.sramDrdy  (sramDrdy),
		.sramData  (sramData),
		.sramTag   (sramTag),
		.ioDrdy    (ioDrdy),
		.ioData    (ioData),
		.ioTag     (ioTag),
		.rspDrdy   (rspDrdy),
		.rspData   (rspData),
		.rspTag    (rspTag),
		.ioRspSeen (ioRspSeen)
	);

	tickTimer i_tickTimer (
		.EXTCLK (EXTCLK),
		.rstN   (rstN),
		.tick   (tick)
	);

endmodule

`default_nettype wire

// ==== design/responseRouter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nodeBus_consts.svh"

module responseRouter
(
	input  wire                       EXTCLK,
	input  wire                       rstN,
	input  wire                       sramDrdy,
	input  wire  [`DATA_W-1:0]        sramData,
	input  wire  [`BUS_TAG_W-1:0]     sramTag,
	input  wire                       ioDrdy,
	input  wire  [`DATA_W-1:0]        ioData,
	input  wire  [`BUS_TAG_W-1:0]     ioTag,
	output logic [`NUM_REQ-1:0]       rspDrdy,
	output logic [`DATA_W-1:0]        rspData,
	output logic [`REQ_TAG_W-1:0]     rspTag,
	output logic                      ioRspSeen
);

	import nodeBusPkg::*;

	localparam int PTR_W = $clog2(`IO_MAX_OUT);
	localparam int CNT_W = $clog2(`IO_MAX_OUT + 1);

	logic [`DATA_W-1:0]    qData [`IO_MAX_OUT];
	logic [`BUS_TAG_W-1:0] qTag [`IO_MAX_OUT];
	logic [PTR_W-1:0]      wrPtr;
	logic [PTR_W-1:0]      rdPtr;
	logic [CNT_W-1:0]      qCnt;
	logic                  pop;
	logic                  selValid;
	logic [`DATA_W-1:0]    selData;
	logic [`BUS_TAG_W-1:0] selTag;
	reqIdT                 selId;

	// ==============================
	// io response queue
	// ==============================

	// queue drains only when sram is idle
	assign pop       = !sramDrdy && (qCnt != '0);
	assign ioRspSeen = pop;

	always_ff @(posedge EXTCLK)
	begin
		if (ioDrdy)
		begin
			qData[wrPtr] <= ioData;
			qTag[wrPtr]  <= ioTag;
		end
	end

	always_ff @(posedge EXTCLK)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			qCnt  <= '0;
		end
		else
		begin
			if (ioDrdy)
				wrPtr <= (wrPtr == PTR_W'(`IO_MAX_OUT - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == PTR_W'(`IO_MAX_OUT - 1)) ? '0 : rdPtr + 1'b1;
			if (ioDrdy && !pop)
				qCnt <= qCnt + 1'b1;
			else if (!ioDrdy && pop)
				qCnt <= qCnt - 1'b1;
		end
	end

	// ==============================
	// return path
	// ==============================

	assign selValid = sramDrdy || pop;
	assign selData  = sramDrdy ? sramData : qData[rdPtr];
	assign selTag   = sramDrdy ? sramTag : qTag[rdPtr];
	assign selId    = selTag[`BUS_TAG_W-1:`REQ_TAG_W];

	always_ff @(posedge EXTCLK)
	begin
		if (!rstN)
			rspDrdy <= '0;
		else
			for (int i = 0; i < `NUM_REQ; i++)
				rspDrdy[i] <= selValid && (selId == reqIdT'(i));
	end

	// requester id stripped off the returned tag
	always_ff @(posedge EXTCLK)
	begin
		rspData <= selData;
		rspTag  <= selTag[`REQ_TAG_W-1:0];
	end

endmodule

`default_nettype wire

// ==== design/busArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nodeBus_consts.svh"

module busArbiter
(
	input  wire                                    EXTCLK,
	input  wire                                    rstN,
	input  wire  [`NUM_REQ-1:0]                    reqAct,
	input  nodeBusPkg::busCmdE [`NUM_REQ-1:0]      reqCmd,
	input  wire  [`NUM_REQ-1:0][`ADDR_W-1:0]       reqAddr,
	input  wire  [`NUM_REQ-1:0][`DATA_W-1:0]       reqData,
	input  wire  [`NUM_REQ-1:0][`BE_W-1:0]         reqBe,
	input  wire  [`NUM_REQ-1:0][`REQ_TAG_W-1:0]    reqTag,
	input  wire                                    ioNext,
	input  wire                                    ioRspSeen,
	output logic [`NUM_REQ-1:0]                    reqNext,
	output nodeBusPkg::busCmdE                     cmd,
	output logic [`ADDR_W-1:0]                     addr,
	output logic [`DATA_W-1:0]                     data,
	output logic [`BE_W-1:0]                       be,
	output logic [`BUS_TAG_W-1:0]                  busTag,
	output logic                                   sramAct,
	output logic                                   ioAct
);

	import nodeBusPkg::*;

	localparam int OUT_W = $clog2(`IO_MAX_OUT + 1);

	logic [`NUM_REQ-1:0] laneIo;
	logic [`NUM_REQ-1:0] laneIoRd;
	logic [`NUM_REQ-1:0] eligible;
	logic                canAccept;
	logic                found;
	logic                incOut;
	reqIdT               winner;
	reqIdT               lastPtr;
	logic [OUT_W-1:0]    outCnt;

	// ==============================
	// request selection
	// ==============================

	// top address bit steers to the io channel
	always_comb
	begin
		for (int i = 0; i < `NUM_REQ; i++)
		begin
			laneIo[i]   = reqAddr[i][`ADDR_W-1];
			laneIoRd[i] = reqAddr[i][`ADDR_W-1] && (reqCmd[i] == CMD_READ);
		end
	end

	// nothing new while io waits or a granted io request is about to issue
	assign canAccept = (!ioAct || ioNext) && !((|reqNext) && laneIo[lastPtr]);

	always_comb
	begin
		for (int i = 0; i < `NUM_REQ; i++)
		begin
			eligible[i] = canAccept && reqAct[i] && !reqNext[i]
				&& !(laneIoRd[i] && (outCnt >= `IO_MAX_OUT));
		end
	end

	// search starts just past the last grant
	always_comb
	begin
		int idx;
		found  = 1'b0;
		winner = '0;
		for (int k = 1; k <= `NUM_REQ; k++)
		begin
			idx = (int'(lastPtr) + k) % `NUM_REQ;
			if (!found && eligible[idx])
			begin
				found  = 1'b1;
				winner = reqIdT'(idx);
			end
		end
	end

	assign incOut = found && laneIoRd[winner];

	always_ff @(posedge EXTCLK)
	begin
		if (!rstN)
		begin
			reqNext <= '0;
			lastPtr <= reqIdT'(`NUM_REQ - 1);
		end
		else
		begin
			reqNext <= '0;
			if (found)
			begin
				reqNext[winner] <= 1'b1;
				lastPtr         <= winner;
			end
		end
	end

	// io reads granted and not yet returned
	always_ff @(posedge EXTCLK)
	begin
		if (!rstN)
			outCnt <= '0;
		else if (incOut && !ioRspSeen)
			outCnt <= outCnt + 1'b1;
		else if (!incOut && ioRspSeen)
			outCnt <= outCnt - 1'b1;
	end

	// ==============================
	// issue stage
	// ==============================

	// granted lane is still held stable by its requester here
	always_ff @(posedge EXTCLK)
	begin
		if (|reqNext)
		begin
			cmd    <= reqCmd[lastPtr];
			addr   <= reqAddr[lastPtr];
			data   <= reqData[lastPtr];
			be     <= reqBe[lastPtr];
			busTag <= {lastPtr, reqTag[lastPtr]};
		end
	end

	always_ff @(posedge EXTCLK)
	begin
		if (!rstN)
		begin
			sramAct <= 1'b0;
			ioAct   <= 1'b0;
		end
		else if (|reqNext)
		begin
			sramAct <= !laneIo[lastPtr];
			ioAct   <= laneIo[lastPtr];
		end
		else
		begin
			sramAct <= 1'b0;
			if (ioNext)
				ioAct <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== design/localSram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nodeBus_consts.svh"

module localSram
(
	input  wire                           EXTCLK,
	input  wire                           sramAct,
	input  nodeBusPkg::busCmdE            cmd,
	input  wire  [`SRAM_WORD_BITS-1:0]    addr,
	input  wire  [`BE_W-1:0]              be,
	input  wire  [`DATA_W-1:0]            data,
	input  wire  [`BUS_TAG_W-1:0]         busTag,
	output logic                          sramDrdy,
	output logic [`DATA_W-1:0]            sramData,
	output logic [`BUS_TAG_W-1:0]         sramTag
);

	import nodeBusPkg::*;

	localparam int DEPTH = 2 ** `SRAM_WORD_BITS;

	logic [`DATA_W-1:0] mem [DEPTH];
	logic               doRead;
	logic               doWrite;

	assign doRead  = sramAct && (cmd == CMD_READ);
	assign doWrite = sramAct && (cmd == CMD_WRITE);

	// ==============================
	// storage
	// ==============================

	// one lane per byte enable
	always_ff @(posedge EXTCLK)
	begin
		if (doWrite)
		begin
			for (int b = 0; b < `BE_W; b++)
			begin
				if (be[b])
					mem[addr][b*8 +: 8] <= data[b*8 +: 8];
			end
		end
	end

	// read data and tag one clock later
	always_ff @(posedge EXTCLK)
	begin
		sramDrdy <= doRead;
		if (doRead)
		begin
			sramData <= mem[addr];
			sramTag  <= busTag;
		end
	end

endmodule

`default_nettype wire

// ==== design/tickTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nodeBus_consts.svh"

module tickTimer
(
	input  wire  EXTCLK,
	input  wire  rstN,
	output logic tick
);

	localparam int CNT_W = $clog2(`TCK_SCALE);

	logic [CNT_W-1:0] cnt;

	// wraps at scale minus one, tick marks the wrap
	always_ff @(posedge EXTCLK)
	begin
		if (!rstN)
		begin
			cnt  <= '0;
			tick <= 1'b0;
		end
		else if (cnt == CNT_W'(`TCK_SCALE - 1))
		begin
			cnt  <= '0;
			tick <= 1'b1;
		end
		else
		begin
			cnt  <= cnt + 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== design/nodeBusPkg.sv ====
`default_nettype none

`include "nodeBus_consts.svh"

package nodeBusPkg;

	// ==============================
	// bus opcodes
	// ==============================

	typedef enum logic
	{
		CMD_READ  = 1'b0,
		CMD_WRITE = 1'b1
	} busCmdE;

	// ==============================
	// requester index
	// ==============================

	// 0 context, 1 stream, 2 message
	typedef logic [$clog2(`NUM_REQ)-1:0] reqIdT;

endpackage

`default_nettype wire

// ==== include/nodeBus_consts.svh ====
`ifndef NODEBUS_CONSTS_SVH
`define NODEBUS_CONSTS_SVH

// requesters on the node bus
`define NUM_REQ 3

// request payload
`define ADDR_W 45
`define DATA_W 64
`define BE_W 8

// requester tag, and the bus tag with the requester id on top
`define REQ_TAG_W 9
`define BUS_TAG_W 11

// sram depth, word index from address bits [14:3]
`define SRAM_WORD_BITS 12

// io reads allowed in flight
`define IO_MAX_OUT 4

// time-base period in clocks
`define TCK_SCALE 20

`endif
